//--- design/decode_pkg.sv
// Decode types: opcode and mode enums, register numbers, micro-op, bundle, record, offsets
`default_nettype none

package decode_pkg;

	// ==============================
	// Encodings
	// ==============================

	// Major opcodes; any value not listed here is undefined
	typedef enum logic [6:0] {
		OP_NOP   = 7'd0,
		OP_ADD   = 7'd1,
		OP_SUB   = 7'd2,
		OP_AND   = 7'd3,
		OP_OR    = 7'd4,
		OP_ADDI  = 7'd8,
		OP_LOAD  = 7'd16,
		OP_STB   = 7'd20,
		OP_STW   = 7'd21,
		OP_STORE = 7'd22,
		OP_R3B   = 7'd32,
		OP_R3W   = 7'd33,
		OP_SYS   = 7'd48,
		OP_REXT  = 7'd80,
		OP_IMMC  = 7'd81
	} opcode_t;

	// Value 2 is reserved
	typedef enum logic [1:0] {
		OM_USER    = 2'd0,
		OM_SUPER   = 2'd1,
		OM_MACHINE = 2'd3
	} operating_mode_t;

	typedef logic [6:0] aregno_t;

	// First member is the most significant, so opcode lands in bits 6..0
	typedef struct packed {
		logic [20:0] imm21;
		logic [4:0]  rs3;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		opcode_t     opcode;
	} micro_op_t;

	typedef struct packed {
		logic [47:0] parcel1;
		micro_op_t   parcel0;
	} bundle_t;

	typedef struct packed {
		opcode_t     opcode;
		aregno_t     rd;
		aregno_t     rs1;
		aregno_t     rs2;
		aregno_t     rs3;
		logic        rdz;
		logic        rs1z;
		logic        rs2z;
		logic        rs3z;
		logic [63:0] imm;
		logic        has_immc;
		// Parcels consumed by this instruction, 1 or 2
		logic [1:0]  len;
		logic        illegal;
	} decoded_t;

	// ==============================
	// Postfix field positions
	// ==============================

	// REXT carries four 7-bit register fields above its opcode
	localparam int PF_RD_LSB  = 7;
	localparam int PF_RS1_LSB = 14;
	localparam int PF_RS2_LSB = 21;
	localparam int PF_RS3_LSB = 28;
	// IMMC carries a 41-bit constant in bits 47..7
	localparam int PF_IMMC_LSB = 7;
	localparam int IMMC_W      = 41;

	// APB register offsets
	localparam logic [3:0] REG_MODE = 4'h0;
	localparam logic [3:0] REG_NDEC = 4'h4;
	localparam logic [3:0] REG_NILL = 4'h8;
	localparam logic [3:0] REG_CLR  = 4'hC;

	// Stores take their data register from the Rd slot and have no destination
	function automatic logic is_store(input opcode_t op);
		return op inside {OP_STB, OP_STW, OP_STORE};
	endfunction

	// The postfix opcode sits in the low bits of parcel 1, as in parcel 0
	function automatic logic pf_is_rext(input logic [47:0] p);
		return p[6:0] == OP_REXT;
	endfunction

	function automatic logic pf_is_immc(input logic [47:0] p);
		return p[6:0] == OP_IMMC;
	endfunction

endpackage

`default_nettype wire

//--- design/decode_rs3.sv
// Third-source register decoder with zero flag
`timescale 1ns/1ps
`default_nettype none

module decode_rs3 import decode_pkg::*; (
	input  micro_op_t instr,
	input  bundle_t   bundle,
	input  logic      has_immc,
	output aregno_t   rs3,
	output logic      rs3z
);

	logic has_rext;
	aregno_t rext_rs3;

	// The REXT Rs3 field overrides the short slot whatever its source
	assign has_rext = pf_is_rext(bundle.parcel1);
	assign rext_rs3 = bundle.parcel1[PF_RS3_LSB +: 7];

	always_comb
	begin
		// A constant postfix occupies the third operand, so Rs3 reads zero
		if (has_immc)
			rs3 = '0;
		else if (is_store(instr.opcode))
			// Store data comes from the Rd slot
			rs3 = has_rext ? rext_rs3 : {2'b00, instr.rd};
		else if (instr.opcode == OP_R3B || instr.opcode == OP_R3W)
			rs3 = has_rext ? rext_rs3 : {2'b00, instr.rs3};
		else
			rs3 = '0;
		rs3z = ~|rs3;
	end

endmodule

`default_nettype wire

//--- design/decode_regs.sv
// Rd, Rs1 and Rs2 decoder with REXT widening and zero flags
`timescale 1ns/1ps
`default_nettype none

module decode_regs import decode_pkg::*; (
	input  bundle_t bundle,
	output aregno_t rd,
	output aregno_t rs1,
	output aregno_t rs2,
	output logic    rdz,
	output logic    rs1z,
	output logic    rs2z
);

	micro_op_t ir;
	logic has_rext;
	logic use_rd;
	logic use_rs1;
	logic use_rs2;

	assign ir = bundle.parcel0;
	assign has_rext = pf_is_rext(bundle.parcel1);

	always_comb
	begin
		// NOP and the stores write nothing back
		use_rd = !(ir.opcode == OP_NOP || is_store(ir.opcode));
		use_rs1 = ir.opcode != OP_NOP;
		// Two-register ALU ops, store index and the three-source group read Rs2
		use_rs2 = ir.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_R3B, OP_R3W}
			|| is_store(ir.opcode);

		// Wide fields from the postfix, or the short slots zero-extended
		if (has_rext)
		begin
			rd  = bundle.parcel1[PF_RD_LSB +: 7];
			rs1 = bundle.parcel1[PF_RS1_LSB +: 7];
			rs2 = bundle.parcel1[PF_RS2_LSB +: 7];
		end
		else
		begin
			rd  = {2'b00, ir.rd};
			rs1 = {2'b00, ir.rs1};
			rs2 = {2'b00, ir.rs2};
		end

		// Registers the opcode does not touch read as r0
		if (!use_rd)
			rd = '0;
		if (!use_rs1)
			rs1 = '0;
		if (!use_rs2)
			rs2 = '0;

		rdz  = ~|rd;
		rs1z = ~|rs1;
		rs2z = ~|rs2;
	end

endmodule

`default_nettype wire

//--- design/decode_imm.sv
// Immediate extractor, postfix detection and instruction length
`timescale 1ns/1ps
`default_nettype none

module decode_imm import decode_pkg::*; (
	input  bundle_t     bundle,
	output logic [63:0] imm,
	output logic        has_immc,
	output logic [1:0]  len
);

	micro_op_t ir;
	logic has_rext;
	logic [IMMC_W-1:0] immc;

	assign ir = bundle.parcel0;
	assign has_rext = pf_is_rext(bundle.parcel1);
	assign has_immc = pf_is_immc(bundle.parcel1);
	assign immc = bundle.parcel1[PF_IMMC_LSB +: IMMC_W];

	always_comb
	begin
		// The postfix constant takes priority over the short field
		if (has_immc)
			imm = {{(64-IMMC_W){immc[IMMC_W-1]}}, immc};
		else if (ir.opcode == OP_ADDI || ir.opcode == OP_LOAD || is_store(ir.opcode))
			imm = {{43{ir.imm21[20]}}, ir.imm21};
		else
			imm = '0;
	end

	// Either kind of postfix consumes the second parcel
	assign len = (has_rext || has_immc) ? 2'd2 : 2'd1;

endmodule

`default_nettype wire

//--- design/decode_stage.sv
// Decode pipeline stage: field decoders, illegal check and the output register
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            in_valid,
	input  bundle_t         in_bundle,
	output logic            in_ready,
	output logic            out_valid,
	output decoded_t        out_dec,
	input  logic            out_ready,
	input  operating_mode_t om,
	output logic            dec_fire,
	output logic            dec_illegal
);

	decoded_t dec_next;
	opcode_t op;
	logic known_op;
	logic postfix_op;
	logic priv_fault;
	logic in_fire;

	// ==============================
	// Field decoders
	// ==============================

	decode_regs decode_regs_inst (
		.bundle(in_bundle),
		.rd    (dec_next.rd),
		.rs1   (dec_next.rs1),
		.rs2   (dec_next.rs2),
		.rdz   (dec_next.rdz),
		.rs1z  (dec_next.rs1z),
		.rs2z  (dec_next.rs2z)
	);

	decode_imm decode_imm_inst (
		.bundle  (in_bundle),
		.imm     (dec_next.imm),
		.has_immc(dec_next.has_immc),
		.len     (dec_next.len)
	);

	// Rs3 depends on the constant postfix found by the immediate decoder
	decode_rs3 decode_rs3_inst (
		.instr   (in_bundle.parcel0),
		.bundle  (in_bundle),
		.has_immc(dec_next.has_immc),
		.rs3     (dec_next.rs3),
		.rs3z    (dec_next.rs3z)
	);

	assign op = in_bundle.parcel0.opcode;
	assign dec_next.opcode = op;

	// Postfix opcodes are defined values but never valid as a micro-op
	always_comb
	begin
		case (op)
			OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LOAD,
			OP_STB, OP_STW, OP_STORE, OP_R3B, OP_R3W, OP_SYS,
			OP_REXT, OP_IMMC:
				known_op = 1'b1;
			default:
				known_op = 1'b0;
		endcase
		postfix_op = op == OP_REXT || op == OP_IMMC;
		// System ops need supervisor or machine mode at the time of accept
		priv_fault = op == OP_SYS && om == OM_USER;
		dec_next.illegal = !known_op || postfix_op || priv_fault;
	end

	// ==============================
	// Output register
	// ==============================

	// Accept while the register is empty or draining this cycle
	assign in_ready = !out_valid || out_ready;
	assign in_fire = in_valid && in_ready;

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_fire)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// Record holds under back-pressure because in_fire stays low
	always_ff @(posedge clk)
	begin
		if (in_fire)
			out_dec <= dec_next;
	end

	// One pulse per output transfer for the status counters
	assign dec_fire = out_valid && out_ready;
	assign dec_illegal = dec_fire && out_dec.illegal;

endmodule

`default_nettype wire

//--- design/decode_csr.sv
// APB register block: operating mode and saturating decode/illegal counters
`timescale 1ns/1ps
`default_nettype none

module decode_csr import decode_pkg::*; #(
	parameter int CNT_W = 16
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  logic [3:0]      paddr,
	input  logic [31:0]     pwdata,
	output logic [31:0]     prdata,
	output logic            pready,
	output logic            pslverr,
	output operating_mode_t om,
	input  logic            dec_fire,
	input  logic            dec_illegal
);

	logic [CNT_W-1:0] ndec;
	logic [CNT_W-1:0] nill;
	logic access;
	logic addr_hit;
	logic wr_mode;
	logic clr;

	// No wait states, so every access phase completes at once
	assign pready = 1'b1;
	assign access = psel && penable;
	assign addr_hit = paddr inside {REG_MODE, REG_NDEC, REG_NILL, REG_CLR};
	assign pslverr = access && !addr_hit;

	assign wr_mode = access && pwrite && paddr == REG_MODE;
	assign clr = access && pwrite && paddr == REG_CLR && pwdata[0];

	// Machine mode out of reset so system ops decode as legal
	always_ff @(posedge clk)
	begin
		if (rst)
			om <= OM_MACHINE;
		else if (wr_mode)
			om <= operating_mode_t'(pwdata[1:0]);
	end

	// ==============================
	// Counters
	// ==============================

	// Clear has priority over a same-cycle increment; both stick at all ones
	always_ff @(posedge clk)
	begin
		if (rst || clr)
		begin
			ndec <= '0;
			nill <= '0;
		end
		else
		begin
			if (dec_fire && !(&ndec))
				ndec <= ndec + 1'b1;
			if (dec_illegal && !(&nill))
				nill <= nill + 1'b1;
		end
	end

	// Read data is only driven during a read access phase
	always_comb
	begin
		prdata = '0;
		if (access && !pwrite)
			case (paddr)
				REG_MODE: prdata = {30'd0, om};
				REG_NDEC: prdata = 32'(ndec);
				REG_NILL: prdata = 32'(nill);
				default:  prdata = '0;
			endcase
	end

endmodule

`default_nettype wire

//--- design/decode_top.sv
// Decode front end top: pipeline stage plus APB configuration and status block
`timescale 1ns/1ps
`default_nettype none

module decode_top import decode_pkg::*; #(
	parameter int CNT_W = 16
) (
	input  logic        clk,
	input  logic        rst,
	// Instruction stream
	input  logic        in_valid,
	input  bundle_t     in_bundle,
	output logic        in_ready,
	output logic        out_valid,
	output decoded_t    out_dec,
	input  logic        out_ready,
	// APB slave
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	operating_mode_t om;
	logic dec_fire;
	logic dec_illegal;

	decode_stage decode_stage_inst (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_bundle  (in_bundle),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_dec    (out_dec),
		.out_ready  (out_ready),
		.om         (om),
		.dec_fire   (dec_fire),
		.dec_illegal(dec_illegal)
	);

	// Mode feeds the illegal check, transfer pulses feed the counters
	decode_csr #(
		.CNT_W(CNT_W)
	) decode_csr_inst (
		.clk        (clk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.om         (om),
		.dec_fire   (dec_fire),
		.dec_illegal(dec_illegal)
	);

endmodule

`default_nettype wire

//--- verif/decode_checker.sv
// Output monitor: expected-record table, field compare and error count
`timescale 1ns/1ps
`default_nettype none

module decode_checker import decode_pkg::*; #(
	parameter int N_TESTS = 20
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     out_valid,
	input  logic     out_ready,
	input  decoded_t out_dec,
	output int       err_count,
	output logic     done
);

	// One 220-bit word per test line, same layout as the stimulus side
	logic [219:0] vec_mem [N_TESTS];
	int idx = 0;
	int n_err = 0;

	initial
	begin
		$readmemh("verif/decode_testdata.txt", vec_mem);
	end

	assign err_count = n_err;
	assign done = idx == N_TESTS;

	task automatic compare_field(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %0d ns: record %0d %s expected 0x%0h, got 0x%0h",
				$time, idx, name, exp, act);
			n_err++;
		end
	endtask

	// ==============================
	// Compare on each transfer
	// ==============================

	// Valid and ready are stable at the falling edge, and the transfer
	// completes on the rising edge that follows
	always @(negedge clk)
	begin
		logic [219:0] vec;
		if (!rst && out_valid && out_ready)
		begin
			if (idx >= N_TESTS)
			begin
				$display("Output record appeared after all %0d expected records", N_TESTS);
				n_err++;
			end
			else
			begin
				vec = vec_mem[idx];
				compare_field("opcode", 64'(vec[119:112]), 64'(out_dec.opcode));
				compare_field("rd", 64'(vec[111:104]), 64'(out_dec.rd));
				compare_field("rs1", 64'(vec[103:96]), 64'(out_dec.rs1));
				compare_field("rs2", 64'(vec[95:88]), 64'(out_dec.rs2));
				compare_field("rs3", 64'(vec[87:80]), 64'(out_dec.rs3));
				// Zero flags sit in one hex digit, rdz highest
				compare_field("rdz", 64'(vec[79]), 64'(out_dec.rdz));
				compare_field("rs1z", 64'(vec[78]), 64'(out_dec.rs1z));
				compare_field("rs2z", 64'(vec[77]), 64'(out_dec.rs2z));
				compare_field("rs3z", 64'(vec[76]), 64'(out_dec.rs3z));
				compare_field("imm", vec[75:12], out_dec.imm);
				compare_field("has_immc", 64'(vec[8]), 64'(out_dec.has_immc));
				compare_field("len", 64'(vec[5:4]), 64'(out_dec.len));
				compare_field("illegal", 64'(vec[0]), 64'(out_dec.illegal));
				idx++;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_decode_top.sv
// Testbench top: clock, reset, file stimulus, APB accesses, watchdog, DUT and checker
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top import decode_pkg::*; ();

	localparam int N_TESTS = 20;
	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 8;
	localparam int WATCHDOG_CYCLES = N_TESTS * 40 + 200;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	bundle_t in_bundle;
	logic in_ready;
	logic out_valid;
	decoded_t out_dec;
	logic out_ready = 1'b0;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	// Line layout: mode [219:216], parcel1 [215:168], parcel0 [167:120], expected record below
	logic [219:0] vec_mem [N_TESTS];
	logic [15:0] lfsr_state = 16'd65064;
	int tb_errors = 0;
	int chk_errors;
	logic chk_done;

	always #(CLK_PERIOD / 2) clk = ~clk;

	decode_top #(
		.CNT_W(16)
	) decode_top_inst (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_bundle(in_bundle),
		.in_ready (in_ready),
		.out_valid(out_valid),
		.out_dec  (out_dec),
		.out_ready(out_ready),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr)
	);

	decode_checker #(
		.N_TESTS(N_TESTS)
	) decode_checker_inst (
		.clk      (clk),
		.rst      (rst),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_dec  (out_dec),
		.err_count(chk_errors),
		.done     (chk_done)
	);

	// ==============================
	// Back-pressure
	// ==============================

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One step per cycle, and the bit shifted out becomes out_ready
	always @(posedge clk)
	begin
		lfsr_state <= lfsr_next(lfsr_state);
		out_ready <= lfsr_state[15];
	end

	// ==============================
	// Bus and stream tasks
	// ==============================

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		// The write lands on this access-phase edge
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
		output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_reg(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
			tb_errors++;
		end
	endtask

	// Returns on the edge that accepts the bundle
	task automatic send_bundle(input bundle_t b);
		in_valid <= 1'b1;
		in_bundle <= b;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		@(posedge clk);
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		int n_ill;
		logic [1:0] cur_mode;
		logic [1:0] line_mode;
		logic [31:0] rdata;
		logic rerr;
		rst = 1'b1;
		in_valid = 1'b0;
		in_bundle = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		n_ill = 0;
		cur_mode = OM_MACHINE;
		$readmemh("verif/decode_testdata.txt", vec_mem);

		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < N_TESTS; i++)
		begin
			line_mode = vec_mem[i][217:216];
			if (vec_mem[i][0])
				n_ill++;
			// The stream pauses so that the new mode applies only to later bundles
			if (line_mode != cur_mode)
			begin
				in_valid <= 1'b0;
				apb_write(REG_MODE, 32'(line_mode));
				cur_mode = line_mode;
			end
			send_bundle(vec_mem[i][215:120]);
		end
		in_valid <= 1'b0;

		while (!chk_done)
			@(posedge clk);

		apb_read(REG_NDEC, rdata, rerr);
		check_reg("REG_NDEC", 32'(N_TESTS), rdata);
		check_reg("pslverr", 32'd0, 32'(rerr));
		apb_read(REG_NILL, rdata, rerr);
		check_reg("REG_NILL", 32'(n_ill), rdata);
		apb_read(REG_MODE, rdata, rerr);
		check_reg("REG_MODE", 32'(cur_mode), rdata);

		// Both counters clear together
		apb_write(REG_CLR, 32'd1);
		apb_read(REG_NDEC, rdata, rerr);
		check_reg("REG_NDEC", 32'd0, rdata);
		apb_read(REG_NILL, rdata, rerr);
		check_reg("REG_NILL", 32'd0, rdata);

		apb_read(4'h2, rdata, rerr);
		if (!rerr)
		begin
			$display("A read of unmapped address 0x2 completed without an APB error");
			tb_errors++;
		end

		$display("Errors: %0d in output records, %0d in register accesses",
			chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Ends a stalled run well after the longest expected stream
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
design/decode_pkg.sv
design/decode_rs3.sv
design/decode_regs.sv
design/decode_imm.sv
design/decode_stage.sv
design/decode_csr.sv
design/decode_top.sv
verif/decode_checker.sv
verif/tb_decode_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the decode front-end testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_decode
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_decode_top \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- verif/decode_testdata.txt
// Columns: mode, parcel1, parcel0, then expected opcode, rd, rs1, rs2, rs3,
// zero flags (rdz rs1z rs2z rs3z), imm, has_immc, len, illegal
3_000000000000_000000062081_01_01_02_03_00_1_0000000000000000_0_1_0
3_000000000000_000001C05002_02_00_05_00_00_B_0000000000000000_0_1_0
3_000000000000_FFFFD8126208_08_04_06_00_00_3_FFFFFFFFFFFFFFFB_0_1_0
3_000000000000_00080000B510_10_0A_0B_00_00_3_0000000000000100_0_1_0
3_000000000000_000080DCD615_15_00_0D_0E_0C_8_0000000000000010_0_1_0
3_000000000000_000007C620A0_20_01_02_03_1F_0_0000000000000000_0_1_0
3_0002181FF250_0000004210A1_21_64_7F_40_21_0_0000000000000000_0_2_0
3_00005C001050_000000000001_01_20_00_60_00_5_0000000000000000_0_2_0
3_000500D17FD0_FFFFF8083116_16_00_45_06_50_8_FFFFFFFFFFFFFFFF_0_2_0
3_FFFFFFFFF851_000028004188_08_03_04_00_00_3_FFFFFFFFFFFFFFF0_1_2_0
3_55E6F7891A51_0000029283A1_21_07_08_09_00_1_000000ABCDEF1234_1_2_0
3_000000000000_0000000020B0_30_01_02_00_00_3_0000000000000000_0_1_0
3_000000000000_000000001085_05_01_01_00_00_3_0000000000000000_0_1_1
3_000000000000_000000000050_50_00_00_00_00_F_0000000000000000_0_1_1
3_000000000000_000000003180_00_00_00_00_00_F_0000000000000000_0_1_0
0_000000000000_0000000020B0_30_01_02_00_00_3_0000000000000000_0_1_1
0_000000000000_000000062081_01_01_02_03_00_1_0000000000000000_0_1_0
0_000000000000_00000000007F_7F_00_00_00_00_F_0000000000000000_0_1_1
1_000000000000_0000000020B0_30_01_02_00_00_3_0000000000000000_0_1_0
1_000000000000_000000000051_51_00_00_00_00_F_0000000000000000_0_1_1
